//--- ltpi_mgmt_top.f
+incdir+common
common/ltpi_pkg.sv
logic/ltpi_frame_arbiter.sv
gpio/ltpi_gpio_tunnel.sv
data_channel/ltpi_dc_axil_bridge.sv
logic/ltpi_mgmt_top.sv
dv/ltpi_mgmt_assert.sv
dv/ltpi_mgmt_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the LTPI management layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module ltpi_mgmt_tb -f ltpi_mgmt_top.f \
    && ./obj_dir/Vltpi_mgmt_tb +verilator+error+limit+100 \
    || exit 1

//--- dv/ltpi_mgmt_tb.sv
// LTPI management layer testbench
`timescale 1ns/1ps
`include "ltpi_defines.svh"

module ltpi_mgmt_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int TEST_CYCLES = 2000;   // Whole run is well under this
    localparam int HS_LIMIT    = 200;    // Cycles allowed for one AXI handshake
    localparam int GPIO_HOLD   = 160;    // Longer than the checker's hold window
    localparam int AW_RDY      = 0;
    localparam int B_VLD       = 1;
    localparam int AR_RDY      = 2;
    localparam int R_VLD       = 3;

    logic                       clk = 1'b0;
    logic                       rst_n_i;
    logic                       link_up_i;
    logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_i;
    logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_o;
    logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_i;
    logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_o;
    logic                       nl_gpio_stable_o;
    ltpi_pkg::ltpi_frame_t      tx_frame_o;
    logic                       tx_valid_o;
    logic                       tx_ready_i;
    ltpi_pkg::ltpi_frame_t      rx_frame_i;
    logic                       rx_valid_i;
    logic [31:0]                awaddr_i;
    logic                       awvalid_i;
    logic                       awready_o;
    logic [31:0]                wdata_i;
    logic [3:0]                 wstrb_i;
    logic                       wvalid_i;
    logic                       wready_o;
    logic [1:0]                 bresp_o;
    logic                       bvalid_o;
    logic                       bready_i;
    logic [31:0]                araddr_i;
    logic                       arvalid_i;
    logic                       arready_o;
    logic [31:0]                rdata_o;
    logic [1:0]                 rresp_o;
    logic                       rvalid_o;
    logic                       rready_i;

    logic [31:0]                lfsr = 32'hbdbe_3348;
    int                         cyc  = 0;
    ltpi_pkg::ltpi_frame_t      sched_frame [32];   // Receive slots by cycle
    logic                       sched_vld   [32];
    logic [31:0]                remote_mem  [16];
    logic [31:0]                exp_mem     [16];
    ltpi_pkg::ltpi_frame_t      rsp_frame;
    int                         slot;

    ltpi_mgmt_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, why);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        abort_run("Read data differs from the model memory");
    endtask

    function automatic logic axi_flag(input int which);
        case (which)
            AW_RDY:  return awready_o;
            B_VLD:   return bvalid_o;
            AR_RDY:  return arready_o;
            default: return rvalid_o;
        endcase
    endfunction

    // Returns at the falling edge before the cycle that completes the handshake
    task automatic wait_for(input int which, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!axi_flag(which)) begin
            n = n + 1;
            if (n > HS_LIMIT) begin
                abort_run({what, " did not arrive in time"});
            end
            @(negedge clk);
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        wait_for(AW_RDY, "Write address ready");
        next_drive_point();
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        wait_for(B_VLD, "Write response");
        next_drive_point();
        bready_i  = 1'b1;   // B held one cycle first
        next_drive_point();
        bready_i  = 1'b0;
        exp_mem[addr[5:2]] = data;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp,
                            input logic drop_link);
        araddr_i  = addr;
        arvalid_i = 1'b1;
        wait_for(AR_RDY, "Read address ready");
        next_drive_point();
        arvalid_i = 1'b0;
        if (drop_link) begin
            link_up_i = 1'b0;
        end
        wait_for(R_VLD, "Read data");
        if (rdata_o !== exp) begin
            report_mismatch("rdata_o", rdata_o, exp);
        end
        next_drive_point();
        rready_i = 1'b1;
        next_drive_point();
        rready_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Link side: random ready and delayed receive frames
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        #1;
        cyc        = cyc + 1;
        lfsr       = lfsr_next(lfsr);
        tx_ready_i = lfsr[0];
        rx_valid_i = sched_vld[cyc % 32];
        rx_frame_i = sched_frame[cyc % 32];
        sched_vld[cyc % 32] = 1'b0;
    end

    // Remote side model, frame taken at the coming rising edge
    always @(negedge clk) begin
        if (rst_n_i && tx_valid_o && tx_ready_i) begin
            rsp_frame = tx_frame_o;
            if (tx_frame_o.subtype == `LTPI_SUB_IO) begin
                slot = cyc + 4;   // IO frames loop back
            end else begin
                slot = cyc + 9;
                rsp_frame.payload.dc.status = '0;
                if (tx_frame_o.payload.dc.command == `LTPI_DC_CMD_WR) begin
                    remote_mem[tx_frame_o.payload.dc.address[5:2]] = tx_frame_o.payload.dc.data;
                end else begin
                    rsp_frame.payload.dc.data = remote_mem[tx_frame_o.payload.dc.address[5:2]];
                end
            end
            while (sched_vld[slot % 32]) begin
                slot = slot + 1;   // One receive frame per cycle
            end
            sched_vld[slot % 32]   = 1'b1;
            sched_frame[slot % 32] = rsp_frame;
        end
    end

    always @(negedge clk) begin
        if (dut.u_assert.fail_cnt != 0) begin
            abort_run("A checker assertion failed");
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        abort_run("Watchdog timeout, the test did not finish");
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        rst_n_i    = 1'b0;
        link_up_i  = 1'b0;
        ll_gpio_i  = '0;
        nl_gpio_i  = '0;
        tx_ready_i = 1'b0;
        rx_frame_i = '0;
        rx_valid_i = 1'b0;
        awaddr_i   = '0;
        awvalid_i  = 1'b0;
        wdata_i    = '0;
        wstrb_i    = 4'hF;
        wvalid_i   = 1'b0;
        bready_i   = 1'b0;
        araddr_i   = '0;
        arvalid_i  = 1'b0;
        rready_i   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            sched_vld[i] = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            remote_mem[i] = 32'h5a00_c3c3 ^ (i * 32'h0101_0107);
            exp_mem[i]    = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n_i   = 1'b1;
        link_up_i = 1'b1;

        // GPIO tunneling with two held input sets
        ll_gpio_i = 16'h3c5a;
        nl_gpio_i = 64'h0123_4567_89ab_cdef;
        repeat (GPIO_HOLD) next_drive_point();
        ll_gpio_i = 16'hc3a5;
        nl_gpio_i = 64'hfedc_ba98_7654_3210;
        repeat (GPIO_HOLD) next_drive_point();

        // Data channel writes, then reads of the same words
        for (int i = 0; i < 4; i++) begin
            axi_write(32'h0000_1000 + i * 4, 32'h1357_9bdf ^ (i * 32'h1111_1111));
        end
        for (int i = 0; i < 4; i++) begin
            axi_read(32'h0000_1000 + i * 4, exp_mem[i], 1'b0);
        end

        // Link lost during a pending read
        axi_read(32'h0000_1008, 32'h0, 1'b1);
        repeat (8) next_drive_point();
        link_up_i = 1'b1;
        repeat (16) next_drive_point();

        if (dut.u_assert.fail_cnt != 0) begin
            abort_run("Checker assertions failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- dv/ltpi_mgmt_assert.sv
// LTPI management layer checker
`timescale 1ns/1ps
`include "ltpi_defines.svh"

module ltpi_mgmt_assert (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       link_up_i,
    input logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_i,
    input logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_o,
    input logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_i,
    input logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_o,
    input logic                       nl_gpio_stable_o,
    input ltpi_pkg::ltpi_frame_t      tx_frame_o,
    input logic                       tx_valid_o,
    input logic                       tx_ready_i,
    input ltpi_pkg::ltpi_frame_t      rx_frame_i,
    input logic                       rx_valid_i,
    input logic                       awready_o,
    input logic                       wready_o,
    input logic                       arready_o,
    input logic [1:0]                 bresp_o,
    input logic                       bvalid_o,
    input logic                       bready_i,
    input logic [31:0]                rdata_o,
    input logic [1:0]                 rresp_o,
    input logic                       rvalid_o,
    input logic                       rready_i
);

    localparam int HOLD_CYCLES = 128;   // Enough for every slice to make the round trip

    logic                       rx_io;
    logic                       tx_dc;
    logic                       rx_io_q;
    ltpi_pkg::io_payload_t      rx_pl_q;
    logic [3:0]                 seen_q;
    logic                       last_dc_q;
    logic [7:0]                 req_tag_q;
    logic [31:0]                rsp_data_q;
    logic                       pend_q;
    logic                       drop_q;
    logic [`LTPI_LL_GPIO_W-1:0] ll_prev_q;
    logic [`LTPI_NL_GPIO_W-1:0] nl_prev_q;
    int unsigned                hold_cnt_q;
    int unsigned                fail_cnt = 0;

    assign rx_io = rx_valid_i && link_up_i && (rx_frame_i.subtype == `LTPI_SUB_IO);
    assign tx_dc = tx_valid_o && tx_ready_i && (tx_frame_o.subtype == `LTPI_SUB_DC);

    // ------------------------------------------------------------------------
    // Reference state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_io_q    <= 1'b0;
            rx_pl_q    <= '0;
            seen_q     <= '0;
            last_dc_q  <= 1'b0;
            req_tag_q  <= '0;
            rsp_data_q <= '0;
            pend_q     <= 1'b0;
            drop_q     <= 1'b0;
            ll_prev_q  <= '0;
            nl_prev_q  <= '0;
            hold_cnt_q <= 0;
        end else begin
            rx_io_q   <= rx_io;
            rx_pl_q   <= rx_frame_i.payload.io;
            ll_prev_q <= ll_gpio_i;
            nl_prev_q <= nl_gpio_i;
            if (!link_up_i) begin
                seen_q <= '0;
            end else if (rx_io) begin
                seen_q[rx_frame_i.payload.io.nl_index[1:0]] <= 1'b1;
            end
            if (tx_valid_o && tx_ready_i) begin
                last_dc_q <= tx_dc;
            end
            if (tx_dc) begin
                req_tag_q <= tx_frame_o.payload.dc.tag;
            end
            if (rx_valid_i && (rx_frame_i.subtype == `LTPI_SUB_DC) &&
                (rx_frame_i.payload.dc.tag == req_tag_q)) begin
                rsp_data_q <= rx_frame_i.payload.dc.data;
            end
            if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
                pend_q <= 1'b0;
                drop_q <= 1'b0;
            end else begin
                if (awready_o || arready_o) begin
                    pend_q <= 1'b1;
                end
                if (pend_q && !bvalid_o && !rvalid_o && !link_up_i) begin
                    drop_q <= 1'b1;   // Access lost with the link
                end
            end
            if (!link_up_i || (ll_gpio_i != ll_prev_q) || (nl_gpio_i != nl_prev_q)) begin
                hold_cnt_q <= 0;
            end else if (hold_cnt_q < HOLD_CYCLES) begin
                hold_cnt_q <= hold_cnt_q + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n_i || $rose(rst_n_i)) |-> !(tx_valid_o || awready_o || wready_o ||
        arready_o || bvalid_o || rvalid_o || nl_gpio_stable_o))
        else begin
            fail_cnt++;
            $error("Outputs active during or right after reset");
        end

    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_frame_o))
        else begin
            fail_cnt++;
            $error("Transmit frame changed while not taken");
        end

    a_dc_spacing: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_dc |-> !last_dc_q)
        else begin
            fail_cnt++;
            $error("Two data channel frames taken back to back");
        end

    a_rx_io_apply: assert property (@(posedge clk) disable iff (!rst_n_i)
        rx_io_q |-> (ll_gpio_o == rx_pl_q.ll_gpio) &&
        (nl_gpio_o[rx_pl_q.nl_index[1:0]*`LTPI_NL_SLICE_W +: `LTPI_NL_SLICE_W] ==
         rx_pl_q.nl_slice))
        else begin
            fail_cnt++;
            $error("Received IO frame not applied to the GPIO outputs");
        end

    a_nl_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        nl_gpio_stable_o == (link_up_i && (&seen_q)))
        else begin
            fail_cnt++;
            $error("NL stable flag does not match the received slices");
        end

    a_gpio_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        hold_cnt_q >= HOLD_CYCLES |-> (nl_gpio_o == nl_prev_q) && (ll_gpio_o == ll_prev_q))
        else begin
            fail_cnt++;
            $error("GPIO outputs differ from inputs held long enough");
        end

    a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n_i)
        (bvalid_o || rvalid_o) && !drop_q |-> (bvalid_o ? bresp_o : rresp_o) == 2'b00 &&
        (!rvalid_o || (rdata_o == rsp_data_q)))
        else begin
            fail_cnt++;
            $error("Completed access without OKAY or with wrong read data");
        end

    a_link_loss: assert property (@(posedge clk) disable iff (!rst_n_i)
        (bvalid_o || rvalid_o) && drop_q |-> (bvalid_o ? bresp_o : rresp_o) == 2'b10 &&
        (!rvalid_o || (rdata_o == '0)))
        else begin
            fail_cnt++;
            $error("Access lost with the link did not end in SLVERR with zero data");
        end

endmodule

bind ltpi_mgmt_top ltpi_mgmt_assert u_assert (.*);

//--- logic/ltpi_mgmt_top.sv
// LTPI management frame layer top
`timescale 1ns/1ps
`include "ltpi_defines.svh"

module ltpi_mgmt_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       link_up_i,
    // GPIO pins
    input  logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_i,
    output logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_o,
    input  logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_i,
    output logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_o,
    output logic                       nl_gpio_stable_o,
    // Link side
    output ltpi_pkg::ltpi_frame_t      tx_frame_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    input  ltpi_pkg::ltpi_frame_t      rx_frame_i,
    input  logic                       rx_valid_i,
    // AXI4-Lite slave
    input  logic [31:0]                awaddr_i,
    input  logic                       awvalid_i,
    output logic                       awready_o,
    input  logic [31:0]                wdata_i,
    input  logic [3:0]                 wstrb_i,
    input  logic                       wvalid_i,
    output logic                       wready_o,
    output logic [1:0]                 bresp_o,
    output logic                       bvalid_o,
    input  logic                       bready_i,
    input  logic [31:0]                araddr_i,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    output logic [31:0]                rdata_o,
    output logic [1:0]                 rresp_o,
    output logic                       rvalid_o,
    input  logic                       rready_i
);

    ltpi_pkg::io_payload_t io_payload;
    ltpi_pkg::dc_req_t     dc_req;
    logic                  dc_req_valid;
    logic                  dc_taken;
    logic                  io_sent;

    // ------------------------------------------------------------------------
    // Transmit slot arbitration
    // ------------------------------------------------------------------------
    ltpi_frame_arbiter u_arbiter (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .io_payload_i   (io_payload),
        .dc_req_valid_i (dc_req_valid),
        .dc_req_i       (dc_req),
        .tx_ready_i     (tx_ready_i),
        .tx_frame_o     (tx_frame_o),
        .tx_valid_o     (tx_valid_o),
        .io_sent_o      (io_sent),
        .dc_taken_o     (dc_taken)
    );

    ltpi_gpio_tunnel u_gpio (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .link_up_i        (link_up_i),
        .ll_gpio_i        (ll_gpio_i),
        .nl_gpio_i        (nl_gpio_i),
        .io_sent_i        (io_sent),
        .io_payload_o     (io_payload),
        .rx_frame_i       (rx_frame_i),
        .rx_valid_i       (rx_valid_i),
        .ll_gpio_o        (ll_gpio_o),
        .nl_gpio_o        (nl_gpio_o),
        .nl_gpio_stable_o (nl_gpio_stable_o)
    );

    // Controller side data channel
    ltpi_dc_axil_bridge u_dc_bridge (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .link_up_i      (link_up_i),
        .awaddr_i       (awaddr_i),
        .awvalid_i      (awvalid_i),
        .awready_o      (awready_o),
        .wdata_i        (wdata_i),
        .wstrb_i        (wstrb_i),
        .wvalid_i       (wvalid_i),
        .wready_o       (wready_o),
        .bresp_o        (bresp_o),
        .bvalid_o       (bvalid_o),
        .bready_i       (bready_i),
        .araddr_i       (araddr_i),
        .arvalid_i      (arvalid_i),
        .arready_o      (arready_o),
        .rdata_o        (rdata_o),
        .rresp_o        (rresp_o),
        .rvalid_o       (rvalid_o),
        .rready_i       (rready_i),
        .dc_req_valid_o (dc_req_valid),
        .dc_req_o       (dc_req),
        .dc_taken_i     (dc_taken),
        .rx_frame_i     (rx_frame_i),
        .rx_valid_i     (rx_valid_i)
    );

endmodule

//--- data_channel/ltpi_dc_axil_bridge.sv
// LTPI data channel AXI4-Lite bridge
`timescale 1ns/1ps
`include "ltpi_defines.svh"

module ltpi_dc_axil_bridge (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  link_up_i,
    // AXI4-Lite slave
    input  logic [31:0]           awaddr_i,
    input  logic                  awvalid_i,
    output logic                  awready_o,
    input  logic [31:0]           wdata_i,
    input  logic [3:0]            wstrb_i,
    input  logic                  wvalid_i,
    output logic                  wready_o,
    output logic [1:0]            bresp_o,
    output logic                  bvalid_o,
    input  logic                  bready_i,
    input  logic [31:0]           araddr_i,
    input  logic                  arvalid_i,
    output logic                  arready_o,
    output logic [31:0]           rdata_o,
    output logic [1:0]            rresp_o,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    // Frame side
    output logic                  dc_req_valid_o,
    output ltpi_pkg::dc_req_t     dc_req_o,
    input  logic                  dc_taken_i,
    input  ltpi_pkg::ltpi_frame_t rx_frame_i,
    input  logic                  rx_valid_i
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;   // Waiting for the transmit slot
    localparam logic [1:0] ST_WAIT = 2'd2;   // Waiting for the response frame
    localparam logic [1:0] ST_RESP = 2'd3;   // B or R channel held

    logic [1:0]              state_q;
    logic [7:0]              tag_q;
    logic                    rd_q;
    logic                    wr_acc;
    logic                    rd_acc;
    logic                    rsp_hit;
    logic                    link_drop;
    ltpi_pkg::dc_payload_t   req_q;
    ltpi_pkg::dc_payload_t   rsp;
    ltpi_pkg::axi_resp_e     resp_q;

    // Writes win when both arrive together
    assign wr_acc    = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
    assign rd_acc    = (state_q == ST_IDLE) && arvalid_i && !(awvalid_i && wvalid_i);
    assign awready_o = wr_acc;
    assign wready_o  = wr_acc;
    assign arready_o = rd_acc;

    assign rsp       = rx_frame_i.payload.dc;
    assign rsp_hit   = rx_valid_i && (rx_frame_i.subtype == `LTPI_SUB_DC) &&
                       (rsp.tag == req_q.tag);
    assign link_drop = !link_up_i && ((state_q == ST_REQ) || (state_q == ST_WAIT));

    // ------------------------------------------------------------------------
    // Request frame payload
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_acc || rd_acc) begin
            req_q.tag       <= tag_q;
            req_q.command   <= wr_acc ? `LTPI_DC_CMD_WR : `LTPI_DC_CMD_RD;
            req_q.address   <= wr_acc ? awaddr_i : araddr_i;
            req_q.status    <= '0;
            req_q.byte_en   <= wr_acc ? wstrb_i : 4'hF;
            req_q.data      <= wr_acc ? wdata_i : '0;
            req_q.zero_fill <= '0;
        end
    end

    assign dc_req_o.payload = req_q;
    assign dc_req_valid_o   = (state_q == ST_REQ);

    // ------------------------------------------------------------------------
    // Access FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            tag_q   <= '0;
            rd_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_acc || rd_acc) begin
                        state_q <= ST_REQ;
                        tag_q   <= tag_q + 8'd1;   // Fresh tag per access
                        rd_q    <= rd_acc;
                    end
                end
                ST_REQ: begin
                    if (link_drop) begin
                        state_q <= ST_RESP;
                    end else if (dc_taken_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (link_drop || rsp_hit) begin
                        state_q <= ST_RESP;
                    end
                end
                default: begin
                    if (rd_q ? rready_i : bready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Response code and read data
    always_ff @(posedge clk) begin
        if (link_drop) begin
            resp_q  <= ltpi_pkg::AXI_SLVERR;
            rdata_o <= '0;
        end else if ((state_q == ST_WAIT) && rsp_hit) begin
            resp_q  <= (rsp.status == '0) ? ltpi_pkg::AXI_OKAY : ltpi_pkg::AXI_SLVERR;
            rdata_o <= rd_q ? rsp.data : '0;
        end
    end

    assign bresp_o  = resp_q;
    assign rresp_o  = resp_q;
    assign bvalid_o = (state_q == ST_RESP) && !rd_q;
    assign rvalid_o = (state_q == ST_RESP) &&  rd_q;

endmodule

//--- gpio/ltpi_gpio_tunnel.sv
// LTPI GPIO tunnel
`timescale 1ns/1ps
`include "ltpi_defines.svh"

module ltpi_gpio_tunnel (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       link_up_i,
    input  logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_i,
    input  logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_i,
    input  logic                       io_sent_i,
    output ltpi_pkg::io_payload_t      io_payload_o,
    input  ltpi_pkg::ltpi_frame_t      rx_frame_i,
    input  logic                       rx_valid_i,
    output logic [`LTPI_LL_GPIO_W-1:0] ll_gpio_o,
    output logic [`LTPI_NL_GPIO_W-1:0] nl_gpio_o,
    output logic                       nl_gpio_stable_o
);

    localparam int IDX_W = $clog2(`LTPI_NL_FRM_CNT);

    logic [`LTPI_LL_GPIO_W-1:0]  ll_in_q;
    logic [`LTPI_NL_GPIO_W-1:0]  nl_in_q;
    logic [IDX_W-1:0]            tx_idx_q;
    logic [IDX_W-1:0]            tx_idx;
    logic [IDX_W-1:0]            rx_idx;
    logic                        rx_io;
    logic [`LTPI_NL_FRM_CNT-1:0] seen_q;   // NL slices received since link up

    // ------------------------------------------------------------------------
    // Transmit side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        ll_in_q <= ll_gpio_i;
        nl_in_q <= nl_gpio_i;
    end

    // Index of the IO frame loaded next, one ahead once the current one is sent
    always_comb begin
        tx_idx = tx_idx_q;
        if (io_sent_i) begin
            if (tx_idx_q == IDX_W'(`LTPI_NL_FRM_CNT - 1)) begin
                tx_idx = '0;
            end else begin
                tx_idx = tx_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_idx_q <= '0;
        end else begin
            tx_idx_q <= tx_idx;
        end
    end

    always_comb begin
        io_payload_o          = '0;
        io_payload_o.nl_index = 8'(tx_idx);
        io_payload_o.ll_gpio  = ll_in_q;
        io_payload_o.nl_slice = nl_in_q[tx_idx*`LTPI_NL_SLICE_W +: `LTPI_NL_SLICE_W];
    end

    // ------------------------------------------------------------------------
    // Receive side
    // ------------------------------------------------------------------------
    assign rx_io  = rx_valid_i && (rx_frame_i.subtype == `LTPI_SUB_IO);
    assign rx_idx = rx_frame_i.payload.io.nl_index[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ll_gpio_o <= '1;
            nl_gpio_o <= '1;
            seen_q    <= '0;
        end else if (!link_up_i) begin
            ll_gpio_o <= '1;                                // Back to safe levels
            nl_gpio_o <= '1;
            seen_q    <= '0;
        end else if (rx_io) begin
            ll_gpio_o <= rx_frame_i.payload.io.ll_gpio;
            nl_gpio_o[rx_idx*`LTPI_NL_SLICE_W +: `LTPI_NL_SLICE_W] <=
                rx_frame_i.payload.io.nl_slice;
            seen_q[rx_idx] <= 1'b1;
        end
    end

    assign nl_gpio_stable_o = link_up_i & (&seen_q);

endmodule

//--- logic/ltpi_frame_arbiter.sv
// LTPI transmit frame arbiter
`timescale 1ns/1ps
`include "ltpi_defines.svh"

module ltpi_frame_arbiter (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  ltpi_pkg::io_payload_t io_payload_i,
    input  logic                  dc_req_valid_i,
    input  ltpi_pkg::dc_req_t     dc_req_i,
    input  logic                  tx_ready_i,
    output ltpi_pkg::ltpi_frame_t tx_frame_o,
    output logic                  tx_valid_o,
    output logic                  io_sent_o,
    output logic                  dc_taken_o
);

    logic                  accept;
    logic                  load;
    logic                  sel_dc;
    logic                  last_dc_q;   // Slot holds a data channel frame
    ltpi_pkg::ltpi_frame_t frame_nxt;

    assign accept = tx_valid_o & tx_ready_i;
    assign load   = accept | ~tx_valid_o;   // Empty slot only right after reset

    // Data channel frames never go out back to back
    assign sel_dc = dc_req_valid_i & ~last_dc_q;

    assign io_sent_o  = accept & ~last_dc_q;
    assign dc_taken_o = accept &  last_dc_q;

    // ------------------------------------------------------------------------
    // Next frame assembly
    // ------------------------------------------------------------------------
    always_comb begin
        frame_nxt.comma = `LTPI_COMMA;
        if (sel_dc) begin
            frame_nxt.subtype    = `LTPI_SUB_DC;
            frame_nxt.payload.dc = dc_req_i.payload;
        end else begin
            frame_nxt.subtype    = `LTPI_SUB_IO;
            frame_nxt.payload.io = io_payload_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_valid_o <= 1'b0;
            last_dc_q  <= 1'b0;
        end else if (load) begin
            tx_valid_o <= 1'b1;
            last_dc_q  <= sel_dc;
        end
    end

    // Frame held until the link side takes it
    always_ff @(posedge clk) begin
        if (load) begin
            tx_frame_o <= frame_nxt;
        end
    end

endmodule

//--- common/ltpi_pkg.sv
// LTPI management frame types
`include "ltpi_defines.svh"

package ltpi_pkg;

    // -----------------------------------------------------------------------
    // Operational IO payload
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic [7:0]                        nl_index;   // NL slice index
        logic [`LTPI_LL_GPIO_W-1:0]        ll_gpio;
        logic [`LTPI_NL_SLICE_W-1:0]       nl_slice;
        logic [`LTPI_FRM_BYTES*8-41:0]     zero_fill;  // OEM bytes, sent as zero
    } io_payload_t;

    // -----------------------------------------------------------------------
    // Data channel payload, requests and responses alike
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic [7:0]                        tag;
        logic [7:0]                        command;
        logic [31:0]                       address;
        logic [3:0]                        status;     // Zero means success
        logic [3:0]                        byte_en;
        logic [31:0]                       data;
        logic [`LTPI_FRM_BYTES*8-89:0]     zero_fill;  // Pads to the frame size
    } dc_payload_t;

    // Subtype selects the decoding
    typedef union packed {
        io_payload_t                       io;
        dc_payload_t                       dc;
    } frame_payload_u;

    typedef struct packed {
        logic [7:0]                        comma;
        logic [7:0]                        subtype;
        frame_payload_u                    payload;
    } ltpi_frame_t;

    // Request handed from the bridge to the arbiter
    typedef struct packed {
        dc_payload_t                       payload;
    } dc_req_t;

    // AXI response codes used by the bridge
    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_SLVERR = 2'b10
    } axi_resp_e;

endpackage

//--- common/ltpi_defines.svh
// LTPI management layer constants
`ifndef LTPI_DEFINES_SVH
`define LTPI_DEFINES_SVH

// ---------------------------------------------------------------------------
// GPIO tunneling widths
// ---------------------------------------------------------------------------
`define LTPI_LL_GPIO_W      16      // Low-latency GPIO, whole in every IO frame
`define LTPI_NL_GPIO_W      64      // Normal-latency GPIO
`define LTPI_NL_SLICE_W     16      // Slice carried per IO frame
`define LTPI_NL_FRM_CNT     4       // Slices needed for a full NL update

// ---------------------------------------------------------------------------
// Frame layout and symbols
// ---------------------------------------------------------------------------
`define LTPI_FRM_BYTES      13      // Payload bytes after comma and subtype
`define LTPI_COMMA          8'hFC   // K28.7
`define LTPI_SUB_IO         8'h00   // Operational IO frame
`define LTPI_SUB_DC         8'h01   // Data channel frame

// Data channel command codes
`define LTPI_DC_CMD_RD      8'h00
`define LTPI_DC_CMD_WR      8'h01

`endif
